// ==== include/psg_config.svh ====
`ifndef PSG_CONFIG_SVH
`define PSG_CONFIG_SVH

// Clocks per generator tick
`define PSG_DIV 64

// Number of host-visible registers
`define PSG_NUM_REGS 16

// Noise LFSR state after reset, must be nonzero
`define PSG_LFSR_SEED 17'd1

`endif

// ==== hw/psg_pkg.sv ====
`default_nettype none

package psg_pkg;

    // Mixer and level controls for one channel
    typedef struct packed {
        logic       tone_off;
        logic       noise_off;
        logic       env_mode;
        logic [3:0] level;
    } psg_chan_ctl_t;

    // Envelope shape, same bit order as register 13
    typedef struct packed {
        logic cont;
        logic attack;
        logic alternate;
        logic hold;
    } psg_env_shape_t;

    // Everything the generators need from the register block.
    // Channel A is index 0 in the arrays
    typedef struct packed {
        logic [2:0][11:0]    tone_period;
        logic [4:0]          noise_period;
        psg_chan_ctl_t [2:0] chan;
        logic [15:0]         env_period;
        psg_env_shape_t      env_shape;
    } psg_regs_t;

endpackage

`default_nettype wire

// ==== hw/psg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "psg_config.svh"

module psg_regs (
    input  logic               clk,
    input  logic               reset,
    input  logic               a0,
    input  logic               wren,
    input  logic [7:0]         wrdata,
    input  logic [7:0]         ioa_in_data,
    input  logic [7:0]         iob_in_data,
    output logic [7:0]         rddata,
    output psg_pkg::psg_regs_t cfg,
    output logic               env_restart
);

    localparam int ADDR_W = $clog2(`PSG_NUM_REGS);

    logic [ADDR_W-1:0] addr;
    logic              reg_wr;
    logic              ioa_dir;
    logic              iob_dir;
    logic [7:0]        ioa_latch;
    logic [7:0]        iob_latch;

    // Data phase of the bus
    assign reg_wr = wren && !a0;

    ////////////////////////////////////////////////////////////////////////////
    // Address latch
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            addr <= '0;
        end else if (wren && a0) begin
            addr <= wrdata[ADDR_W-1:0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg     <= '0;
            ioa_dir <= 1'b0;
            iob_dir <= 1'b0;
            // All channels start muted on both sources
            for (int i = 0; i < 3; i++) begin
                cfg.chan[i].tone_off  <= 1'b1;
                cfg.chan[i].noise_off <= 1'b1;
            end
        end else if (reg_wr) begin
            case (addr)
                4'h0: cfg.tone_period[0][7:0]  <= wrdata;
                4'h1: cfg.tone_period[0][11:8] <= wrdata[3:0];
                4'h2: cfg.tone_period[1][7:0]  <= wrdata;
                4'h3: cfg.tone_period[1][11:8] <= wrdata[3:0];
                4'h4: cfg.tone_period[2][7:0]  <= wrdata;
                4'h5: cfg.tone_period[2][11:8] <= wrdata[3:0];
                4'h6: cfg.noise_period         <= wrdata[4:0];
                4'h7: begin
                    {iob_dir, ioa_dir} <= wrdata[7:6];
                    for (int i = 0; i < 3; i++) begin
                        cfg.chan[i].noise_off <= wrdata[3+i];
                        cfg.chan[i].tone_off  <= wrdata[i];
                    end
                end
                4'h8: {cfg.chan[0].env_mode, cfg.chan[0].level} <= wrdata[4:0];
                4'h9: {cfg.chan[1].env_mode, cfg.chan[1].level} <= wrdata[4:0];
                4'hA: {cfg.chan[2].env_mode, cfg.chan[2].level} <= wrdata[4:0];
                4'hB: cfg.env_period[7:0]  <= wrdata;
                4'hC: cfg.env_period[15:8] <= wrdata;
                4'hD: cfg.env_shape        <= wrdata[3:0];
                default: ;
            endcase
        end
    end

    // Port output latches only feed the read path
    always_ff @(posedge clk) begin
        if (reg_wr && addr == 4'hE) begin
            ioa_latch <= wrdata;
        end
        if (reg_wr && addr == 4'hF) begin
            iob_latch <= wrdata;
        end
    end

    // A shape write restarts the envelope
    always_ff @(posedge clk) begin
        if (reset) begin
            env_restart <= 1'b0;
        end else begin
            env_restart <= reg_wr && addr == 4'hD;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read multiplexer
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rddata = 8'h00;
        case (addr)
            4'h0: rddata = cfg.tone_period[0][7:0];
            4'h1: rddata = {4'b0, cfg.tone_period[0][11:8]};
            4'h2: rddata = cfg.tone_period[1][7:0];
            4'h3: rddata = {4'b0, cfg.tone_period[1][11:8]};
            4'h4: rddata = cfg.tone_period[2][7:0];
            4'h5: rddata = {4'b0, cfg.tone_period[2][11:8]};
            4'h6: rddata = {3'b0, cfg.noise_period};
            4'h7: rddata = {iob_dir, ioa_dir,
                            cfg.chan[2].noise_off, cfg.chan[1].noise_off,
                            cfg.chan[0].noise_off, cfg.chan[2].tone_off,
                            cfg.chan[1].tone_off, cfg.chan[0].tone_off};
            4'h8: rddata = {3'b0, cfg.chan[0].env_mode, cfg.chan[0].level};
            4'h9: rddata = {3'b0, cfg.chan[1].env_mode, cfg.chan[1].level};
            4'hA: rddata = {3'b0, cfg.chan[2].env_mode, cfg.chan[2].level};
            4'hB: rddata = cfg.env_period[7:0];
            4'hC: rddata = cfg.env_period[15:8];
            4'hD: rddata = {4'b0, cfg.env_shape};
            // Direction bit picks latch or pin
            4'hE: rddata = ioa_dir ? ioa_latch : ioa_in_data;
            4'hF: rddata = iob_dir ? iob_latch : iob_in_data;
            default: rddata = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/psg_tone_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "psg_config.svh"

module psg_tone_bank (
    input  logic               clk,
    input  logic               reset,
    input  psg_pkg::psg_regs_t cfg,
    output logic               tick,
    output logic [2:0]         tone_wave
);

    localparam int DIV_W = $clog2(`PSG_DIV);

    logic [DIV_W-1:0] div;

    // Prescaler. Tick is registered off the divider at zero, so it is
    // low in reset and first rises one clock after release
    always_ff @(posedge clk) begin
        if (reset) begin
            div  <= '0;
            tick <= 1'b0;
        end else begin
            if (div == DIV_W'(`PSG_DIV - 1)) begin
                div <= '0;
            end else begin
                div <= div + 1'b1;
            end
            tick <= (div == '0);
        end
    end

    // One period counter per channel
    for (genvar i = 0; i < 3; i++) begin : g_tone
        logic [11:0] count;
        logic        wave;

        always_ff @(posedge clk) begin
            if (reset) begin
                count <= '0;
                wave  <= 1'b0;
            end else if (tick) begin
                // Compare with >= so a shortened period expires at once
                if (count >= cfg.tone_period[i]) begin
                    count <= '0;
                    wave  <= ~wave;
                end else begin
                    count <= count + 12'd1;
                end
            end
        end

        assign tone_wave[i] = wave;
    end

endmodule

`default_nettype wire

// ==== hw/psg_noise.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "psg_config.svh"

module psg_noise (
    input  logic               clk,
    input  logic               reset,
    input  logic               tick,
    input  psg_pkg::psg_regs_t cfg,
    output logic               noise_bit
);

    logic [4:0]  count;
    logic        half;
    logic [16:0] lfsr;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            half  <= 1'b0;
            lfsr  <= `PSG_LFSR_SEED;
        end else if (tick) begin
            if (count >= cfg.noise_period) begin
                count <= '0;
                half  <= ~half;
                // Shift on every second expiry, taps at bits 0 and 3
                if (half) begin
                    lfsr <= {lfsr[0] ^ lfsr[3], lfsr[16:1]};
                end
            end else begin
                count <= count + 5'd1;
            end
        end
    end

    assign noise_bit = lfsr[0];

endmodule

`default_nettype wire

// ==== hw/psg_envelope.sv ====
`timescale 1ns/1ps
`default_nettype none

module psg_envelope (
    input  logic               clk,
    input  logic               reset,
    input  logic               tick,
    input  psg_pkg::psg_regs_t cfg,
    input  logic               env_restart,
    output logic [3:0]         env_level
);

    logic [16:0] period_cnt;
    logic        period_done;
    logic        step;
    logic [3:0]  env_cnt;
    logic        cnt_up;
    logic        stopped;
    logic        restart_pend;

    ////////////////////////////////////////////////////////////////////////////
    // Period counter
    ////////////////////////////////////////////////////////////////////////////

    assign period_done = period_cnt >= {1'b0, cfg.env_period};
    assign step        = tick && period_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            period_cnt <= '0;
        end else if (tick) begin
            if (period_done) begin
                period_cnt <= '0;
            end else begin
                period_cnt <= period_cnt + 17'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Shape FSM
    ////////////////////////////////////////////////////////////////////////////

    // Restart waits here until the next envelope step
    always_ff @(posedge clk) begin
        if (reset) begin
            restart_pend <= 1'b0;
        end else if (env_restart) begin
            restart_pend <= 1'b1;
        end else if (step) begin
            restart_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            env_cnt <= '0;
            cnt_up  <= 1'b0;
            stopped <= 1'b0;
        end else if (step) begin
            if (restart_pend) begin
                env_cnt <= 4'd15;
                cnt_up  <= cfg.env_shape.attack;
                stopped <= 1'b0;
            end else if (!stopped) begin
                if (env_cnt == 4'd0) begin
                    // End of a ramp
                    if (!cfg.env_shape.cont || cfg.env_shape.hold) begin
                        stopped <= 1'b1;
                    end else begin
                        env_cnt <= 4'd15;
                    end
                    if ((cfg.env_shape.cont && cfg.env_shape.alternate) ||
                        (!cfg.env_shape.cont && cfg.env_shape.attack)) begin
                        cnt_up <= ~cnt_up;
                    end
                end else begin
                    env_cnt <= env_cnt - 4'd1;
                end
            end
        end
    end

    // Counter always runs down, rising ramps are the mirror image
    assign env_level = cnt_up ? ~env_cnt : env_cnt;

endmodule

`default_nettype wire

// ==== hw/psg_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

module psg_mixer (
    input  logic               clk,
    input  logic               tick,
    input  psg_pkg::psg_regs_t cfg,
    input  logic [2:0]         tone_wave,
    input  logic               noise_bit,
    input  logic [3:0]         env_level,
    output logic [9:0]         ch_a,
    output logic [9:0]         ch_b,
    output logic [9:0]         ch_c
);

    import psg_pkg::*;

    // Roughly 3 dB per level step, full scale at 15
    localparam logic [9:0] AMP_TABLE [16] = '{
        10'd0,   10'd6,   10'd9,   10'd13,
        10'd19,  10'd27,  10'd39,  10'd56,
        10'd80,  10'd116, 10'd166, 10'd239,
        10'd344, 10'd495, 10'd712, 10'd1023
    };

    logic [9:0] amp [3];

    for (genvar i = 0; i < 3; i++) begin : g_chan
        psg_chan_ctl_t ctl;
        logic          chan_on;
        logic [3:0]    level;

        assign ctl = cfg.chan[i];

        // A disabled source counts as permanently high
        assign chan_on = (tone_wave[i] | ctl.tone_off) & (noise_bit | ctl.noise_off);

        always_comb begin
            if (!chan_on) begin
                level = 4'd0;
            end else if (ctl.env_mode) begin
                level = env_level;
            end else begin
                level = ctl.level;
            end
        end

        // Output only moves on a tick
        always_ff @(posedge clk) begin
            if (tick) begin
                amp[i] <= AMP_TABLE[level];
            end
        end
    end

    assign ch_a = amp[0];
    assign ch_b = amp[1];
    assign ch_c = amp[2];

endmodule

`default_nettype wire

// ==== hw/psg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module psg_top (
    input  logic       clk,
    input  logic       reset,
    input  logic       a0,
    input  logic       wren,
    input  logic [7:0] wrdata,
    output logic [7:0] rddata,
    input  logic [7:0] ioa_in_data,
    input  logic [7:0] iob_in_data,
    output logic [9:0] ch_a,
    output logic [9:0] ch_b,
    output logic [9:0] ch_c
);

    import psg_pkg::*;

    psg_regs_t  cfg;
    logic       env_restart;
    logic       tick;
    logic [2:0] tone_wave;
    logic       noise_bit;
    logic [3:0] env_level;

    psg_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .a0          (a0),
        .wren        (wren),
        .wrdata      (wrdata),
        .ioa_in_data (ioa_in_data),
        .iob_in_data (iob_in_data),
        .rddata      (rddata),
        .cfg         (cfg),
        .env_restart (env_restart)
    );

    // Also owns the tick prescaler
    psg_tone_bank u_tone (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg),
        .tick      (tick),
        .tone_wave (tone_wave)
    );

    psg_noise u_noise (
        .clk       (clk),
        .reset     (reset),
        .tick      (tick),
        .cfg       (cfg),
        .noise_bit (noise_bit)
    );

    psg_envelope u_env (
        .clk         (clk),
        .reset       (reset),
        .tick        (tick),
        .cfg         (cfg),
        .env_restart (env_restart),
        .env_level   (env_level)
    );

    psg_mixer u_mixer (
        .clk       (clk),
        .tick      (tick),
        .cfg       (cfg),
        .tone_wave (tone_wave),
        .noise_bit (noise_bit),
        .env_level (env_level),
        .ch_a      (ch_a),
        .ch_b      (ch_b),
        .ch_c      (ch_c)
    );

endmodule

`default_nettype wire

// ==== tests/psg_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "psg_config.svh"

module psg_props (
    input logic       clk,
    input logic       reset,
    input logic       tick,
    input logic [9:0] ch_a,
    input logic [9:0] ch_b,
    input logic [9:0] ch_c
);

    // Clocks since the last tick, zero until the first one
    logic [7:0] since_tick;

    always_ff @(posedge clk) begin
        if (reset) begin
            since_tick <= '0;
        end else if (tick) begin
            since_tick <= 8'd1;
        end else if (since_tick != '0) begin
            since_tick <= since_tick + 8'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tick timing
    ////////////////////////////////////////////////////////////////////////////

    first_tick: assert property (@(posedge clk) $fell(reset) |=> tick)
        else $error("tick did not follow reset release");

    // One clock wide, exactly PSG_DIV clocks apart
    tick_period: assert property (@(posedge clk) disable iff (reset)
        since_tick != '0 |-> (tick == (since_tick == 8'(`PSG_DIV))))
        else $error("tick spacing wrong, %0d clocks since last tick", since_tick);

    ////////////////////////////////////////////////////////////////////////////
    // Channel outputs
    ////////////////////////////////////////////////////////////////////////////

    chan_stable: assert property (@(posedge clk) disable iff (reset)
        (since_tick != '0 && !$past(tick)) |-> $stable({ch_a, ch_b, ch_c}))
        else $error("channel output moved away from a tick");

    chan_reset: assert property (@(posedge clk)
        $fell(reset) |=> ##1 (ch_a == '0 && ch_b == '0 && ch_c == '0))
        else $error("channels not zero after reset");

endmodule

bind psg_top psg_props u_props (
    .clk   (clk),
    .reset (reset),
    .tick  (tick),
    .ch_a  (ch_a),
    .ch_b  (ch_b),
    .ch_c  (ch_c)
);

`default_nettype wire

// ==== tests/psg_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "psg_config.svh"

module psg_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int N_CASES      = 21;
    // A full envelope ramp at period 1 with margin
    localparam int ENV_WAIT     = `PSG_DIV * 2 * 40;
    localparam int NOISE_WAIT   = `PSG_DIV * 2 * 64;

    // Logarithmic amplitude for each 4-bit level
    localparam logic [9:0] LEVEL_AMP [16] = '{
        10'd0,   10'd6,   10'd9,   10'd13,
        10'd19,  10'd27,  10'd39,  10'd56,
        10'd80,  10'd116, 10'd166, 10'd239,
        10'd344, 10'd495, 10'd712, 10'd1023
    };

    typedef struct packed {
        logic       rnd;
        logic [3:0] num;
        logic [7:0] wval;
        logic [7:0] rval;
        logic [7:0] pin;
    } reg_case_t;

    // rnd set means wval is replaced by a random byte
    localparam reg_case_t CASES [N_CASES] = '{
        '{1'b0, 4'h0, 8'h5A, 8'h5A, 8'h00},
        '{1'b0, 4'h1, 8'hF3, 8'h03, 8'h00},
        '{1'b1, 4'h2, 8'h00, 8'h00, 8'h00},
        '{1'b1, 4'h3, 8'h00, 8'h00, 8'h00},
        '{1'b0, 4'h4, 8'h81, 8'h81, 8'h00},
        '{1'b1, 4'h5, 8'h00, 8'h00, 8'h00},
        '{1'b0, 4'h6, 8'hFF, 8'h1F, 8'h00},
        '{1'b0, 4'h7, 8'h3F, 8'h3F, 8'h00},
        '{1'b0, 4'h8, 8'hFF, 8'h1F, 8'h00},
        '{1'b1, 4'h9, 8'h00, 8'h00, 8'h00},
        '{1'b0, 4'hA, 8'h2C, 8'h0C, 8'h00},
        '{1'b1, 4'hB, 8'h00, 8'h00, 8'h00},
        '{1'b0, 4'hC, 8'h96, 8'h96, 8'h00},
        '{1'b0, 4'hD, 8'hFE, 8'h0E, 8'h00},
        // Direction clear so the ports read the pins
        '{1'b0, 4'hE, 8'h11, 8'hC3, 8'hC3},
        '{1'b0, 4'hF, 8'h22, 8'h7E, 8'h7E},
        '{1'b0, 4'h7, 8'hFF, 8'hFF, 8'h00},
        '{1'b0, 4'hE, 8'h44, 8'h44, 8'hC3},
        '{1'b0, 4'hF, 8'h88, 8'h88, 8'h7E},
        '{1'b0, 4'h7, 8'h3F, 8'h3F, 8'h00},
        '{1'b0, 4'hE, 8'h55, 8'hA5, 8'hA5}
    };

    logic       clk;
    logic       reset;
    logic       a0;
    logic       wren;
    logic [7:0] wrdata;
    logic [7:0] rddata;
    logic [7:0] ioa_in_data;
    logic [7:0] iob_in_data;
    logic [9:0] ch_a;
    logic [9:0] ch_b;
    logic [9:0] ch_c;
    int         seed;

    psg_top uut (
        .clk         (clk),
        .reset       (reset),
        .a0          (a0),
        .wren        (wren),
        .wrdata      (wrdata),
        .rddata      (rddata),
        .ioa_in_data (ioa_in_data),
        .iob_in_data (iob_in_data),
        .ch_a        (ch_a),
        .ch_b        (ch_b),
        .ch_c        (ch_c)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic halt_on_error();
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("FAIL time=%0t %s got=0x%0h expected=0x%0h", $time, name, got, want);
            halt_on_error();
        end
    endtask

    // Unused high bits read back as zero
    function automatic logic [7:0] readback_mask(input logic [3:0] num);
        case (num)
            4'h1, 4'h3, 4'h5, 4'hD: return 8'h0F;
            4'h6, 4'h8, 4'h9, 4'hA: return 8'h1F;
            default: return 8'hFF;
        endcase
    endfunction

    function automatic logic [9:0] chan_value(input int sel);
        case (sel)
            0: return ch_a;
            1: return ch_b;
            default: return ch_c;
        endcase
    endfunction

    task automatic bus_select(input logic [3:0] num);
        @(negedge clk);
        a0     = 1'b1;
        wren   = 1'b1;
        wrdata = {4'h0, num};
        @(negedge clk);
        wren = 1'b0;
        a0   = 1'b0;
    endtask

    task automatic bus_write(input logic [7:0] val);
        @(negedge clk);
        a0     = 1'b0;
        wren   = 1'b1;
        wrdata = val;
        @(negedge clk);
        wren = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] num, input logic [7:0] val);
        bus_select(num);
        bus_write(val);
    endtask

    task automatic wait_channel(input int sel, input logic [9:0] want, input int limit,
                                input string what);
        int n;
        n = 0;
        while (chan_value(sel) != want) begin
            @(negedge clk);
            n++;
            if (n >= limit && chan_value(sel) != want) begin
                $display("Timeout: %s not reached within %0d clock cycles", what, limit);
                halt_on_error();
            end
        end
    endtask

    task automatic hold_channel(input int sel, input logic [9:0] want, input int cycles,
                                input string name);
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk);
            check(name, 32'(chan_value(sel)), 32'(want));
        end
    endtask

    task automatic wait_change_a(input int limit, output int cycles);
        logic [9:0] start;
        start  = ch_a;
        cycles = 0;
        while (ch_a == start) begin
            @(negedge clk);
            cycles++;
            if (cycles >= limit && ch_a == start) begin
                $display("Timeout: ch_a did not change within %0d clock cycles", limit);
                halt_on_error();
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Scenarios
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_fixed_levels(input logic [3:0] la, input logic [3:0] lb,
                                      input logic [3:0] lc);
        int n;
        write_reg(4'h7, 8'h3F);
        write_reg(4'h8, {4'h0, la});
        write_reg(4'h9, {4'h0, lb});
        write_reg(4'hA, {4'h0, lc});
        // Outputs settle within one tick
        n = 0;
        while (n < 2 * `PSG_DIV &&
               !(ch_a == LEVEL_AMP[la] && ch_b == LEVEL_AMP[lb] && ch_c == LEVEL_AMP[lc])) begin
            @(negedge clk);
            n++;
        end
        check("ch_a", 32'(ch_a), 32'(LEVEL_AMP[la]));
        check("ch_b", 32'(ch_b), 32'(LEVEL_AMP[lb]));
        check("ch_c", 32'(ch_c), 32'(LEVEL_AMP[lc]));
    endtask

    task automatic measure_tone(input logic [11:0] period, input logic [3:0] level);
        int         limit;
        int         cycles;
        logic [9:0] prev;
        write_reg(4'h8, {4'h0, level});
        write_reg(4'h0, period[7:0]);
        write_reg(4'h1, {4'h0, period[11:8]});
        write_reg(4'h7, 8'h3E);
        limit = `PSG_DIV * (int'(period) + 3);
        // Counter phase is arbitrary until two edges have passed
        wait_change_a(limit, cycles);
        wait_change_a(limit, cycles);
        for (int k = 0; k < 4; k++) begin
            prev = ch_a;
            wait_change_a(limit, cycles);
            check("tone interval", cycles, `PSG_DIV * (int'(period) + 1));
            check("ch_a", 32'(ch_a), (prev == '0) ? 32'(LEVEL_AMP[level]) : 32'd0);
        end
    endtask

    task automatic check_envelope();
        write_reg(4'h7, 8'h3F);
        write_reg(4'hB, 8'h01);
        write_reg(4'hC, 8'h00);
        // Continue, attack and hold
        write_reg(4'hD, 8'h0D);
        write_reg(4'h9, 8'h10);
        wait_channel(1, 10'd0, ENV_WAIT, "envelope restart at level 0");
        wait_channel(1, LEVEL_AMP[15], ENV_WAIT, "envelope rise to level 15");
        hold_channel(1, LEVEL_AMP[15], 16 * 2 * `PSG_DIV, "ch_b");
        // Single decay that parks at zero
        write_reg(4'hD, 8'h00);
        wait_channel(1, 10'd0, ENV_WAIT, "envelope decay to level 0");
        hold_channel(1, 10'd0, 16 * 2 * `PSG_DIV, "ch_b");
    endtask

    task automatic check_noise(input logic [3:0] level);
        int n;
        bit seen_zero;
        bit seen_level;
        write_reg(4'h6, 8'h00);
        write_reg(4'hA, {4'h0, level});
        write_reg(4'h7, 8'h1F);
        repeat (2 * `PSG_DIV) @(negedge clk);
        n          = 0;
        seen_zero  = 1'b0;
        seen_level = 1'b0;
        while (!(seen_zero && seen_level)) begin
            @(negedge clk);
            n++;
            if (ch_c == '0) begin
                seen_zero = 1'b1;
            end else begin
                check("ch_c", 32'(ch_c), 32'(LEVEL_AMP[level]));
                seen_level = 1'b1;
            end
            if (n >= NOISE_WAIT && !(seen_zero && seen_level)) begin
                $display("Timeout: noise on ch_c did not show both levels in %0d cycles",
                         NOISE_WAIT);
                halt_on_error();
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reg_case_t  tc;
        logic [7:0] wval;
        logic [7:0] want;

        seed        = 32'h334f;
        reset       = 1'b1;
        a0          = 1'b0;
        wren        = 1'b0;
        wrdata      = 8'h00;
        ioa_in_data = 8'h00;
        iob_in_data = 8'h00;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // Register read-back and port direction
        for (int i = 0; i < N_CASES; i++) begin
            tc   = CASES[i];
            wval = tc.wval;
            want = tc.rval;
            if (tc.rnd) begin
                wval = 8'($random(seed));
                want = wval & readback_mask(tc.num);
            end
            // Other port gets the inverse to catch a swapped select
            if (tc.num == 4'hE) begin
                ioa_in_data = tc.pin;
                iob_in_data = ~tc.pin;
            end else if (tc.num == 4'hF) begin
                iob_in_data = tc.pin;
                ioa_in_data = ~tc.pin;
            end
            write_reg(tc.num, wval);
            check($sformatf("rddata(reg %0d)", tc.num), 32'(rddata), 32'(want));
        end

        check_fixed_levels(4'd5, 4'd10, 4'd15);
        check_fixed_levels(4'($random(seed)), 4'($random(seed)), 4'($random(seed)));
        measure_tone(12'd3, 4'd12);
        measure_tone(12'd6, 4'(8 + ($random(seed) & 7)));
        check_envelope();
        check_noise(4'd9);

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
hw/psg_pkg.sv
hw/psg_regs.sv
hw/psg_tone_bank.sv
hw/psg_noise.sv
hw/psg_envelope.sv
hw/psg_mixer.sv
hw/psg_top.sv
tests/psg_props.sv
tests/psg_tb.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= psg_tb
FILELIST ?= build.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
FAIL_MSG := Testbench failed
PASS_MSG := Testbench passed
SRCS     := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run check clean

all: $(BIN)

# Rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without passing"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
